// ==== src/cache_pkg.sv ====
// data cache shared definitions
package cache_pkg;

	// ------------------------------
	// widths
	// ------------------------------
	parameter int word_w         = 32;   // processor word
	parameter int words_per_line = 4;
	parameter int line_w         = word_w * words_per_line;  // 128 bit line

	// processor addresses words, memory addresses whole lines
	parameter int proc_addr_w    = 30;
	parameter int mem_addr_w     = 28;

	// ------------------------------
	// payload types
	// ------------------------------
	typedef logic [word_w-1:0] word_t;
	typedef logic [line_w-1:0] line_t;

	// ------------------------------
	// controller states
	// ------------------------------
	// idle only follows reset; compare is the normal resting state,
	// write_back and allocate are the two miss phases
	typedef enum logic [1:0] {
		idle       = 2'b00,
		compare    = 2'b01,
		write_back = 2'b10,
		allocate   = 2'b11
	} cache_state_t;

endpackage

// ==== src/cache_ctrl.sv ====
// data cache controller
module cache_ctrl #(
	parameter int index_bits = 3
) (
	input  logic                                      clk,
	input  logic                                      proc_reset,
	input  logic                                      proc_read,
	input  logic                                      proc_write,
	input  logic [cache_pkg::proc_addr_w-1:0]         proc_addr,
	input  logic                                      hit,
	input  logic                                      victim_dirty,
	// tag width is proc_addr_w - 2 - index_bits
	input  logic [cache_pkg::proc_addr_w-3-index_bits:0] victim_tag,
	input  cache_pkg::line_t                          line_rdata,
	input  cache_pkg::word_t                          word_rdata,
	input  logic                                      mem_ready,
	output logic                                      proc_stall,
	output cache_pkg::word_t                          proc_rdata,
	output logic                                      mem_read,
	output logic                                      mem_write,
	output logic [cache_pkg::mem_addr_w-1:0]          mem_addr,
	output cache_pkg::line_t                          mem_wdata,
	output logic                                      tag_write,
	output logic                                      set_dirty,
	output logic                                      clear_dirty,
	output logic                                      fill,
	output logic                                      word_write
);

	localparam int off_w = $clog2(cache_pkg::words_per_line);

	cache_pkg::cache_state_t state;
	cache_pkg::cache_state_t next_state;

	logic                  request;
	logic                  hit_now;     // compare cycle with a matching line
	logic [index_bits-1:0] index;

	assign request = proc_read | proc_write;
	assign hit_now = (state == cache_pkg::compare) & hit;
	assign index   = proc_addr[off_w +: index_bits];

	// ------------------------------
	// state register
	// ------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			state <= cache_pkg::idle;   // one dead cycle before compare
		end else begin
			state <= next_state;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			cache_pkg::idle: begin
				next_state = cache_pkg::compare;
			end
			cache_pkg::compare: begin
				// a miss goes through write_back only when the victim is dirty
				if (request && !hit) begin
					if (victim_dirty) begin
						next_state = cache_pkg::write_back;
					end else begin
						next_state = cache_pkg::allocate;
					end
				end
			end
			cache_pkg::write_back: begin
				if (mem_ready) begin
					next_state = cache_pkg::allocate;
				end
			end
			cache_pkg::allocate: begin
				if (mem_ready) begin
					next_state = cache_pkg::compare;  // retry hits next cycle
				end
			end
			default: begin
				next_state = cache_pkg::idle;
			end
		endcase
	end

	// ------------------------------
	// processor side
	// ------------------------------
	assign proc_stall = ~hit_now;
	assign proc_rdata = hit_now ? word_rdata : '0;

	// ------------------------------
	// memory side
	// ------------------------------
	assign mem_read  = (state == cache_pkg::allocate);
	assign mem_write = (state == cache_pkg::write_back);

	// victim line address is rebuilt from its stored tag
	assign mem_addr  = mem_write ? {victim_tag, index}
	                             : proc_addr[cache_pkg::proc_addr_w-1:off_w];
	assign mem_wdata = line_rdata;  // victim line, same index

	// ------------------------------
	// store updates
	// ------------------------------
	assign fill        = mem_read & mem_ready;
	assign tag_write   = fill;                  // new tag, valid and clean
	assign clear_dirty = mem_write & mem_ready;
	assign word_write  = hit_now & proc_write;
	assign set_dirty   = word_write;

	// ------------------------------
	// checks
	// ------------------------------
	// strobe, direction and address hold until memory answers
	a_strobe_hold: assert property (@(posedge clk) disable iff (proc_reset)
		(mem_read || mem_write) && !mem_ready
			|=> mem_read == $past(mem_read) && mem_write == $past(mem_write)
				&& $stable(mem_addr))
		else $error("memory strobe or address changed before mem_ready");

	a_fill_hits: assert property (@(posedge clk) disable iff (proc_reset)
		fill |=> !proc_stall)
		else $error("filled line did not hit on the following compare");

endmodule

// ==== src/cache_tag_store.sv ====
// data cache tag store
module cache_tag_store #(
	parameter int index_bits = 3
) (
	input  logic                                      clk,
	input  logic                                      proc_reset,
	input  logic [cache_pkg::proc_addr_w-1:0]         proc_addr,
	input  logic                                      tag_write,
	input  logic                                      set_dirty,
	input  logic                                      clear_dirty,
	output logic                                      hit,
	output logic                                      victim_dirty,
	output logic [cache_pkg::proc_addr_w-3-index_bits:0] victim_tag
);

	localparam int off_w = $clog2(cache_pkg::words_per_line);
	localparam int tag_w = cache_pkg::proc_addr_w - off_w - index_bits;
	localparam int lines = 1 << index_bits;

	logic [lines-1:0] valid;
	logic [lines-1:0] dirty;
	logic [tag_w-1:0] tags [lines];

	logic [index_bits-1:0] index;
	logic [tag_w-1:0]      req_tag;

	assign index   = proc_addr[off_w +: index_bits];
	assign req_tag = proc_addr[cache_pkg::proc_addr_w-1 -: tag_w];

	// ------------------------------
	// lookup, purely combinational
	// ------------------------------
	assign hit          = valid[index] & (tags[index] == req_tag);
	assign victim_dirty = valid[index] & dirty[index];
	assign victim_tag   = tags[index];

	// ------------------------------
	// state bits
	// ------------------------------
	always_ff @(posedge clk) begin
		if (proc_reset) begin
			valid <= '0;
			dirty <= '0;
		end else begin
			if (tag_write) begin
				valid[index] <= 1'b1;
				dirty[index] <= 1'b0;   // freshly filled line is clean
			end else if (set_dirty) begin
				dirty[index] <= 1'b1;
			end else if (clear_dirty) begin
				dirty[index] <= 1'b0;   // after write-back
			end
		end
	end

	always_ff @(posedge clk) begin
		if (tag_write) begin
			tags[index] <= req_tag;
		end
	end

endmodule

// ==== src/cache_data_store.sv ====
// data cache line store
module cache_data_store #(
	parameter int index_bits = 3
) (
	input  logic                              clk,
	input  logic [cache_pkg::proc_addr_w-1:0] proc_addr,
	input  cache_pkg::word_t                  proc_wdata,
	input  cache_pkg::line_t                  mem_rdata,
	input  logic                              fill,
	input  logic                              word_write,
	output cache_pkg::word_t                  word_rdata,
	output cache_pkg::line_t                  line_rdata
);

	localparam int off_w = $clog2(cache_pkg::words_per_line);
	localparam int lines = 1 << index_bits;

	cache_pkg::line_t lines_q [lines];

	logic [index_bits-1:0] index;
	logic [off_w-1:0]      offset;    // word within line

	assign index  = proc_addr[off_w +: index_bits];
	assign offset = proc_addr[off_w-1:0];

	// ------------------------------
	// read side
	// ------------------------------
	assign line_rdata = lines_q[index];
	assign word_rdata = line_rdata[offset*cache_pkg::word_w +: cache_pkg::word_w];

	// ------------------------------
	// write side
	// ------------------------------
	// fill replaces the whole line, a hit write merges one word
	always_ff @(posedge clk) begin
		if (fill) begin
			lines_q[index] <= mem_rdata;
		end else if (word_write) begin
			lines_q[index][offset*cache_pkg::word_w +: cache_pkg::word_w] <= proc_wdata;
		end
	end

	// controller never fills and merges in one cycle
	a_one_write: assert property (@(posedge clk)
		!(fill && word_write))
		else $error("fill and word_write high together");

endmodule

// ==== src/dcache_top.sv ====
// direct-mapped data cache
module dcache_top #(
	parameter int index_bits = 3    // 8 lines
) (
	input  logic                              clk,
	input  logic                              proc_reset,
	// processor side
	input  logic                              proc_read,
	input  logic                              proc_write,
	input  logic [cache_pkg::proc_addr_w-1:0] proc_addr,
	input  cache_pkg::word_t                  proc_wdata,
	output logic                              proc_stall,
	output cache_pkg::word_t                  proc_rdata,
	// memory side
	output logic                              mem_read,
	output logic                              mem_write,
	output logic [cache_pkg::mem_addr_w-1:0]  mem_addr,
	output cache_pkg::line_t                  mem_wdata,
	input  cache_pkg::line_t                  mem_rdata,
	input  logic                              mem_ready
);

	localparam int tag_w = cache_pkg::proc_addr_w
		- $clog2(cache_pkg::words_per_line) - index_bits;

	// ------------------------------
	// tag store to controller
	// ------------------------------
	logic             hit;
	logic             victim_dirty;
	logic [tag_w-1:0] victim_tag;

	// controller to stores
	logic tag_write;
	logic set_dirty;
	logic clear_dirty;
	logic fill;
	logic word_write;

	// data store to controller
	cache_pkg::word_t word_rdata;
	cache_pkg::line_t line_rdata;

	cache_ctrl #(.index_bits(index_bits)) i_ctrl (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_read    (proc_read),
		.proc_write   (proc_write),
		.proc_addr    (proc_addr),
		.hit          (hit),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag),
		.line_rdata   (line_rdata),
		.word_rdata   (word_rdata),
		.mem_ready    (mem_ready),
		.proc_stall   (proc_stall),
		.proc_rdata   (proc_rdata),
		.mem_read     (mem_read),
		.mem_write    (mem_write),
		.mem_addr     (mem_addr),
		.mem_wdata    (mem_wdata),
		.tag_write    (tag_write),
		.set_dirty    (set_dirty),
		.clear_dirty  (clear_dirty),
		.fill         (fill),
		.word_write   (word_write)
	);

	cache_tag_store #(.index_bits(index_bits)) i_tags (
		.clk          (clk),
		.proc_reset   (proc_reset),
		.proc_addr    (proc_addr),
		.tag_write    (tag_write),
		.set_dirty    (set_dirty),
		.clear_dirty  (clear_dirty),
		.hit          (hit),
		.victim_dirty (victim_dirty),
		.victim_tag   (victim_tag)
	);

	cache_data_store #(.index_bits(index_bits)) i_data (
		.clk        (clk),
		.proc_addr  (proc_addr),
		.proc_wdata (proc_wdata),
		.mem_rdata  (mem_rdata),
		.fill       (fill),
		.word_write (word_write),
		.word_rdata (word_rdata),
		.line_rdata (line_rdata)
	);

endmodule

// ==== sim/dcache_checker.sv ====
// data cache checker
module dcache_checker #(
	parameter int index_bits = 3
) (
	input  logic                              clk,
	input  logic                              proc_reset,
	input  logic                              proc_read,
	input  logic                              proc_write,
	input  logic [cache_pkg::proc_addr_w-1:0] proc_addr,
	input  cache_pkg::word_t                  proc_wdata,
	input  logic                              proc_stall,
	input  cache_pkg::word_t                  proc_rdata,
	input  logic                              mem_read,
	input  logic                              mem_write,
	input  logic [cache_pkg::mem_addr_w-1:0]  mem_addr,
	input  cache_pkg::line_t                  mem_wdata,
	input  logic                              mem_ready,
	input  logic                              expect_fill,
	input  logic                              expect_wb,
	output int                                value_errs,
	output int                                traffic_errs
);
	timeunit 1ns;
	timeprecision 100ps;

	localparam int off_w = $clog2(cache_pkg::words_per_line);

	cache_pkg::word_t shadow [logic [cache_pkg::proc_addr_w-1:0]];   // written words only
	bit               dirty_lines [logic [cache_pkg::mem_addr_w-1:0]];
	int               fills;
	int               write_backs;
	logic             seen_request;

	function automatic cache_pkg::word_t shadow_word(input logic [cache_pkg::proc_addr_w-1:0] a);
		if (shadow.exists(a)) begin
			return shadow[a];
		end
		return {a, 2'b00} ^ 32'h6b3c_91e5;   // untouched memory pattern
	endfunction

	function automatic cache_pkg::line_t shadow_line(input logic [cache_pkg::mem_addr_w-1:0] la);
		cache_pkg::line_t data;
		for (int k = 0; k < cache_pkg::words_per_line; k++) begin
			data[k*cache_pkg::word_w +: cache_pkg::word_w] = shadow_word({la, k[1:0]});
		end
		return data;
	endfunction

	// falling edge, inputs and outputs settled for the coming rising edge
	always @(negedge clk) begin
		if (proc_reset) begin
			value_errs   = 0;
			traffic_errs = 0;
			fills        = 0;
			write_backs  = 0;
			seen_request = 1'b0;
		end else begin
			if (proc_read || proc_write) begin
				seen_request = 1'b1;
			end else if (!seen_request && (!proc_stall || mem_read || mem_write)) begin
				$display("cache not quiet after reset, stall low or a memory strobe high");
				traffic_errs++;
			end

			// ------------------------------
			// memory traffic
			// ------------------------------
			if (mem_ready && mem_read) begin
				fills++;
			end
			if (mem_ready && mem_write) begin
				write_backs++;
				if (!dirty_lines.exists(mem_addr) ||
					mem_addr[index_bits-1:0] != proc_addr[off_w +: index_bits]) begin
					$display("ERROR mem_addr: got %h, not the dirty line at index %h",
						mem_addr, proc_addr[off_w +: index_bits]);
					value_errs++;
				end else begin
					dirty_lines.delete(mem_addr);
				end
				if (mem_wdata !== shadow_line(mem_addr)) begin
					$display("ERROR mem_wdata: got %h expected %h", mem_wdata, shadow_line(mem_addr));
					value_errs++;
				end
			end

			// ------------------------------
			// accepted request
			// ------------------------------
			if ((proc_read || proc_write) && !proc_stall) begin
				if (proc_read && proc_rdata !== shadow_word(proc_addr)) begin
					$display("ERROR proc_rdata at %h: got %h expected %h",
						proc_addr, proc_rdata, shadow_word(proc_addr));
					value_errs++;
				end
				if (proc_write) begin
					shadow[proc_addr] = proc_wdata;
					dirty_lines[proc_addr[cache_pkg::proc_addr_w-1:off_w]] = 1'b1;
				end
				if (fills != (expect_fill ? 1 : 0)) begin
					$display("request at word address %h saw %0d fills, expected %0d",
						proc_addr, fills, expect_fill ? 1 : 0);
					traffic_errs++;
				end
				if (write_backs != (expect_wb ? 1 : 0)) begin
					$display("request at word address %h saw %0d write-backs, expected %0d",
						proc_addr, write_backs, expect_wb ? 1 : 0);
					traffic_errs++;
				end
				fills       = 0;
				write_backs = 0;
			end
		end
	end

endmodule

// ==== sim/tb_dcache.sv ====
// data cache testbench
module tb_dcache;
	timeunit 1ns;
	timeprecision 100ps;

	localparam int index_bits = 3;

	typedef struct packed {
		logic                              wr;
		logic [cache_pkg::proc_addr_w-1:0] addr;
		cache_pkg::word_t                  wdata;
		logic                              fill;  // line expected from memory
		logic                              wb;    // dirty victim expected first
	} step_t;

	localparam int n_steps        = 19;
	localparam int timeout_cycles = n_steps * 12 + 50;

	logic                              clk;
	logic                              proc_reset;
	logic                              proc_read;
	logic                              proc_write;
	logic [cache_pkg::proc_addr_w-1:0] proc_addr;
	cache_pkg::word_t                  proc_wdata;
	logic                              proc_stall;
	cache_pkg::word_t                  proc_rdata;
	logic                              mem_read;
	logic                              mem_write;
	logic [cache_pkg::mem_addr_w-1:0]  mem_addr;
	cache_pkg::line_t                  mem_wdata;
	cache_pkg::line_t                  mem_rdata;
	logic                              mem_ready;
	logic                              expect_fill;
	logic                              expect_wb;
	int                                value_errs;
	int                                traffic_errs;
	int                                cycle_cnt;

	cache_pkg::line_t mem_lines [logic [cache_pkg::mem_addr_w-1:0]];  // lines written back

	// index is word address bits 4:2, tag above
	step_t steps [n_steps] = '{
		'{1'b0, 30'h000_0010, 32'h0000_0000, 1'b1, 1'b0},  // cold miss, index 4
		'{1'b0, 30'h000_0013, 32'h0000_0000, 1'b0, 1'b0},  // same line
		'{1'b1, 30'h000_0011, 32'hdead_beef, 1'b0, 1'b0},  // write hit
		'{1'b0, 30'h000_0011, 32'h0000_0000, 1'b0, 1'b0},
		'{1'b0, 30'h000_0030, 32'h0000_0000, 1'b1, 1'b1},  // dirty index 4 goes out
		'{1'b0, 30'h000_0000, 32'h0000_0000, 1'b1, 1'b0},  // clean miss
		'{1'b1, 30'h000_0002, 32'h1234_5678, 1'b0, 1'b0},
		'{1'b1, 30'h000_0105, 32'h0bad_f00d, 1'b1, 1'b0},  // write allocate, index 1
		'{1'b0, 30'h000_0020, 32'h0000_0000, 1'b1, 1'b1},
		'{1'b0, 30'h000_0125, 32'h0000_0000, 1'b1, 1'b1},
		'{1'b0, 30'h000_0011, 32'h0000_0000, 1'b1, 1'b0},  // evicted data back from memory
		'{1'b0, 30'h000_0002, 32'h0000_0000, 1'b1, 1'b0},
		'{1'b0, 30'h000_0105, 32'h0000_0000, 1'b1, 1'b0},
		'{1'b1, 30'h3fff_fffc, 32'ha5a5_5a5a, 1'b1, 1'b0}, // top tag, index 7
		'{1'b1, 30'h3fff_fffd, 32'h1357_9bdf, 1'b0, 1'b0},
		'{1'b0, 30'h000_001c, 32'h0000_0000, 1'b1, 1'b1},
		'{1'b0, 30'h3fff_fffd, 32'h0000_0000, 1'b1, 1'b0},
		'{1'b0, 30'h3fff_fffe, 32'h0000_0000, 1'b0, 1'b0},
		'{1'b0, 30'h3fff_fffc, 32'h0000_0000, 1'b0, 1'b0}
	};

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	// word k of line L is the byte address {L, k, 00} scrambled
	function automatic cache_pkg::line_t initial_line(input logic [cache_pkg::mem_addr_w-1:0] la);
		cache_pkg::line_t data;
		for (int k = 0; k < cache_pkg::words_per_line; k++) begin
			data[k*cache_pkg::word_w +: cache_pkg::word_w] = {la, k[1:0], 2'b00} ^ 32'h6b3c_91e5;
		end
		return data;
	endfunction

	function automatic cache_pkg::line_t read_line(input logic [cache_pkg::mem_addr_w-1:0] la);
		if (mem_lines.exists(la)) begin
			return mem_lines[la];
		end
		return initial_line(la);
	endfunction

	task automatic apply_step(input step_t s);
		proc_read   = ~s.wr;
		proc_write  = s.wr;
		proc_addr   = s.addr;
		proc_wdata  = s.wdata;
		expect_fill = s.fill;
		expect_wb   = s.wb;
	endtask

	dcache_top #(.index_bits(index_bits)) i_dut (
		.clk        (clk),
		.proc_reset (proc_reset),
		.proc_read  (proc_read),
		.proc_write (proc_write),
		.proc_addr  (proc_addr),
		.proc_wdata (proc_wdata),
		.proc_stall (proc_stall),
		.proc_rdata (proc_rdata),
		.mem_read   (mem_read),
		.mem_write  (mem_write),
		.mem_addr   (mem_addr),
		.mem_wdata  (mem_wdata),
		.mem_rdata  (mem_rdata),
		.mem_ready  (mem_ready)
	);

	dcache_checker #(.index_bits(index_bits)) i_check (
		.clk (clk), .proc_reset (proc_reset),
		.proc_read (proc_read), .proc_write (proc_write),
		.proc_addr (proc_addr), .proc_wdata (proc_wdata),
		.proc_stall (proc_stall), .proc_rdata (proc_rdata),
		.mem_read (mem_read), .mem_write (mem_write),
		.mem_addr (mem_addr), .mem_wdata (mem_wdata), .mem_ready (mem_ready),
		.expect_fill (expect_fill), .expect_wb (expect_wb),
		.value_errs (value_errs), .traffic_errs (traffic_errs)
	);

	initial begin
		clk = 1'b0;
		forever begin
			#10 clk = ~clk;
		end
	end

	// ------------------------------
	// memory model
	// ------------------------------
	initial begin : memory_model
		logic [31:0] rng;
		int          wait_left;
		logic        busy;
		rng       = 32'h2fe9;
		wait_left = 0;
		busy      = 1'b0;
		mem_ready = 1'b0;
		mem_rdata = '0;
		forever begin
			@(posedge clk);
			#2;
			mem_ready = 1'b0;   // single cycle pulse
			if (proc_reset || !(mem_read || mem_write)) begin
				busy = 1'b0;
			end else begin
				if (!busy) begin
					rng       = xorshift32(rng);
					wait_left = 1 + int'(rng % 32'd4);
					busy      = 1'b1;
				end
				wait_left--;
				if (wait_left == 0) begin
					if (mem_write) begin
						mem_lines[mem_addr] = mem_wdata;
					end else begin
						mem_rdata = read_line(mem_addr);
					end
					mem_ready = 1'b1;
					busy      = 1'b0;
				end
			end
		end
	end

	// ------------------------------
	// stimulus
	// ------------------------------
	initial begin : stimulus
		proc_reset  = 1'b1;
		proc_read   = 1'b0;
		proc_write  = 1'b0;
		proc_addr   = '0;
		proc_wdata  = '0;
		expect_fill = 1'b0;
		expect_wb   = 1'b0;
		repeat (3) @(posedge clk);
		#2;
		proc_reset = 1'b0;
		repeat (3) @(posedge clk);   // quiet window after reset
		for (int i = 0; i < n_steps; i++) begin
			#2;
			apply_step(steps[i]);
			do begin
				@(negedge clk);
			end while (proc_stall);
			@(posedge clk);   // taken at this edge
		end
		#2;
		proc_read  = 1'b0;
		proc_write = 1'b0;
		@(negedge clk);
		$display("run done with %0d value errors and %0d traffic errors", value_errs, traffic_errs);
		if (value_errs == 0 && traffic_errs == 0) begin
			$display("All checks passed");
		end else begin
			$display("Checks failed");
		end
		$finish;
	end

	initial begin : watchdog
		cycle_cnt = 0;
		while (cycle_cnt < timeout_cycles) begin
			@(posedge clk);
			cycle_cnt++;
		end
		$display("timeout after %0d cycles with %0d value errors and %0d traffic errors",
			cycle_cnt, value_errs, traffic_errs);
		$display("Checks failed");
		$finish;
	end

endmodule

// ==== dcache.f ====
src/cache_pkg.sv
src/cache_ctrl.sv
src/cache_tag_store.sv
src/cache_data_store.sv
src/dcache_top.sv
sim/dcache_checker.sv
sim/tb_dcache.sv

// ==== Makefile ====
SIM        := verilator
TOP        := tb_dcache
FILELIST   := dcache.f
FLAGS      := --binary --timing --assert --timescale 1ns/100ps -j 0
LINT_FLAGS := --lint-only --timing --assert --timescale 1ns/100ps
OBJ_DIR    := obj_dir
LOG        := sim.log
PASS_MSG   := All checks passed

SOURCES    := $(shell cat $(FILELIST))

.PHONY: all lint sim clean

all: sim

lint:
	$(SIM) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(SIM) $(FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

sim: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "PASS" || (echo "FAIL"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
